// ==== hdl/hps_pkg.sv ====
package hps_pkg;

	////////////////////////////////////////
	// bus and register widths
	////////////////////////////////////////

	typedef logic [15:0] bus_word_t;
	typedef logic [15:0] cmd_t;
	// payload word counter, saturates at all ones
	typedef logic [9:0]  word_idx_t;
	typedef logic [31:0] joy_t;
	typedef logic [31:0] status_t;
	// [10] toggle, [9] pressed, [8] extended, [7:0] scan code
	typedef logic [10:0] key_event_t;
	typedef logic [26:0] dl_addr_t;

	localparam int NUM_JOY = 4;

	////////////////////////////////////////
	// host command codes
	////////////////////////////////////////

	localparam cmd_t CMD_CFG         = 16'h0001;
	localparam cmd_t CMD_JOY0        = 16'h0002;
	localparam cmd_t CMD_JOY1        = 16'h0003;
	localparam cmd_t CMD_KBD         = 16'h0005;
	localparam cmd_t CMD_JOY2        = 16'h0010;
	localparam cmd_t CMD_JOY3        = 16'h0011;
	localparam cmd_t CMD_STATUS      = 16'h001E;
	localparam cmd_t CMD_STATUS_REQ  = 16'h0029;
	localparam cmd_t CMD_FILE_TX     = 16'h0053;
	localparam cmd_t CMD_FILE_TX_DAT = 16'h0054;
	localparam cmd_t CMD_FILE_INDEX  = 16'h0055;

	localparam logic [3:0] STATUS_REQ_TAG = 4'hA;
	localparam logic [7:0] SKIP_MARK      = 8'hFF;

	// scan code prefixes and the multi-byte keys with fixed events
	localparam logic [7:0]  PS2_BREAK        = 8'hF0;
	localparam logic [7:0]  PS2_EXT          = 8'hE0;
	localparam logic [31:0] SEQ_PRNSCR_PRESS = 32'hE012_E07C;
	localparam logic [31:0] SEQ_PRNSCR_REL   = 32'h7CE0_F012;
	localparam logic [31:0] SEQ_PAUSE_PRESS  = 32'hF014_F077;
	localparam logic [9:0]  KEY_PRNSCR_PRESS = 10'h37C;
	localparam logic [9:0]  KEY_PRNSCR_REL   = 10'h17C;
	localparam logic [9:0]  KEY_PAUSE_PRESS  = 10'h377;

	typedef enum logic [1:0] {
		IDLE,
		CMD_WAIT,
		PAYLOAD
	} frame_state_t;

endpackage

// ==== hdl/hps_cmd_frame.sv ====
`timescale 1ns/1ps

module hps_cmd_frame
	import hps_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      io_enable,
	input  logic      io_strobe,
	input  bus_word_t io_din,
	output logic      cmd_strobe,
	output logic      data_strobe,
	output cmd_t      cmd,
	output word_idx_t word_idx,
	output logic      frame_end
);

	frame_state_t state;

	// first strobe of a frame is the command word, the rest is payload
	assign cmd_strobe  = io_enable & io_strobe & (state != PAYLOAD);
	assign data_strobe = io_enable & io_strobe & (state == PAYLOAD);

	////////////////////////////////////////
	// frame machine
	////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state     <= IDLE;
			cmd       <= '0;
			word_idx  <= '0;
			frame_end <= 1'b0;
		end else begin
			frame_end <= 1'b0;
			if (!io_enable) begin
				// enable dropped, close the frame
				if (state != IDLE) begin
					frame_end <= 1'b1;
				end
				state <= IDLE;
				cmd   <= '0;
			end else begin
				case (state)
					IDLE, CMD_WAIT: begin
						if (cmd_strobe) begin
							cmd      <= io_din;
							word_idx <= word_idx_t'(1);
							state    <= PAYLOAD;
						end else begin
							state <= CMD_WAIT;
						end
					end
					PAYLOAD: begin
						// index of the next payload word, held at all ones
						if (data_strobe && !(&word_idx)) begin
							word_idx <= word_idx + 1'b1;
						end
					end
					default: begin
						state <= IDLE;
					end
				endcase
			end
		end
	end

endmodule

// ==== hdl/hps_settings_regs.sv ====
`timescale 1ns/1ps

module hps_settings_regs
	import hps_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      cmd_strobe,
	input  logic      data_strobe,
	input  logic      frame_end,
	input  cmd_t      cmd,
	input  word_idx_t word_idx,
	input  bus_word_t io_din,
	input  status_t   status_in,
	input  logic      status_set,
	output logic [1:0] buttons,
	output logic      forced_scandoubler,
	output status_t   status,
	output joy_t      joystick_0,
	output joy_t      joystick_1,
	output joy_t      joystick_2,
	output joy_t      joystick_3,
	output bus_word_t rdata
);

	logic [7:0]                   cfg;
	joy_t                         joy_r [NUM_JOY];
	logic [$clog2(NUM_JOY)-1:0]   joy_sel;
	logic                         joy_hit;
	logic                         old_status_set;
	logic [3:0]                   flag_cnt;
	status_t                      status_req;

	// cfg bits 2, 3 and 5 are consumed outside the core
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];

	assign joystick_0 = joy_r[0];
	assign joystick_1 = joy_r[1];
	assign joystick_2 = joy_r[2];
	assign joystick_3 = joy_r[3];

	// map joystick command codes onto the register slot
	always_comb begin
		joy_hit = 1'b1;
		joy_sel = '0;
		case (cmd)
			CMD_JOY0: joy_sel = 2'd0;
			CMD_JOY1: joy_sel = 2'd1;
			CMD_JOY2: joy_sel = 2'd2;
			CMD_JOY3: joy_sel = 2'd3;
			default:  joy_hit = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cfg            <= '0;
			status         <= '0;
			old_status_set <= 1'b0;
			flag_cnt       <= '0;
			status_req     <= '0;
			rdata          <= '0;
			for (int i = 0; i < NUM_JOY; i++) begin
				joy_r[i] <= '0;
			end
		end else begin
			// core asks for a status change
			old_status_set <= status_set;
			if (status_set && !old_status_set) begin
				flag_cnt   <= flag_cnt + 1'b1;
				status_req <= status_in;
			end

			if (frame_end) begin
				rdata <= '0;
			end

			if (cmd_strobe) begin
				rdata <= '0;
				if (io_din == CMD_STATUS_REQ) begin
					rdata <= {8'h00, STATUS_REQ_TAG, flag_cnt};
				end
			end

			if (data_strobe) begin
				rdata <= '0;
				case (cmd)
					CMD_CFG: cfg <= io_din[7:0];
					CMD_STATUS: begin
						if (word_idx == 10'd1) status[15:0]  <= io_din;
						if (word_idx == 10'd2) status[31:16] <= io_din;
					end
					CMD_STATUS_REQ: begin
						if (word_idx == 10'd1) rdata <= status_req[15:0];
						if (word_idx == 10'd2) rdata <= status_req[31:16];
					end
					default: ;
				endcase
				// low half first, then high half
				if (joy_hit && word_idx == 10'd1) joy_r[joy_sel][15:0]  <= io_din;
				if (joy_hit && word_idx == 10'd2) joy_r[joy_sel][31:16] <= io_din;
			end
		end
	end

endmodule

// ==== hdl/ps2_key_decoder.sv ====
`timescale 1ns/1ps

module ps2_key_decoder
	import hps_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       cmd_strobe,
	input  logic       data_strobe,
	input  logic       frame_end,
	input  cmd_t       cmd,
	input  bus_word_t  io_din,
	output key_event_t ps2_key
);

	logic [31:0] key_raw;
	logic        skip;
	logic        kbd_frame;
	logic        pressed;
	logic        extended;
	key_event_t  key_next;

	////////////////////////////////////////
	// event decode from the last bytes
	////////////////////////////////////////

	// a release is F0 before the code, extended E0 comes ahead of the F0
	assign pressed  = (key_raw[15:8] != PS2_BREAK);
	assign extended = pressed ? (key_raw[15:8] == PS2_EXT) : (key_raw[23:16] == PS2_EXT);

	always_comb begin
		key_next = {~ps2_key[10], pressed, extended, key_raw[7:0]};
		if (key_raw == SEQ_PRNSCR_PRESS) key_next[9:0] = KEY_PRNSCR_PRESS;
		if (key_raw == SEQ_PRNSCR_REL)   key_next[9:0] = KEY_PRNSCR_REL;
		if (key_raw == SEQ_PAUSE_PRESS)  key_next[9:0] = KEY_PAUSE_PRESS;
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			key_raw   <= '0;
			skip      <= 1'b0;
			kbd_frame <= 1'b0;
			ps2_key   <= '0;
		end else begin
			if (cmd_strobe) begin
				kbd_frame <= (io_din == CMD_KBD);
				if (io_din == CMD_KBD) begin
					key_raw <= '0;
					skip    <= 1'b0;
				end
			end

			if (data_strobe && cmd == CMD_KBD) begin
				if (io_din[15:8] == SKIP_MARK) begin
					skip <= 1'b1;
				end else if (!skip) begin
					key_raw <= {key_raw[23:0], io_din[7:0]};
				end
			end

			// publish once per keyboard frame
			if (frame_end) begin
				kbd_frame <= 1'b0;
				if (kbd_frame && !skip) begin
					ps2_key <= key_next;
				end
			end
		end
	end

endmodule

// ==== hdl/file_download.sv ====
`timescale 1ns/1ps

module file_download
	import hps_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       data_strobe,
	input  cmd_t       cmd,
	input  bus_word_t  io_din,
	output logic       ioctl_download,
	output logic [7:0] ioctl_index,
	output logic       ioctl_wr,
	output dl_addr_t   ioctl_addr,
	output logic [7:0] ioctl_dout
);

	// byte address of the next data word
	dl_addr_t addr;
	logic     wr_pend;

	////////////////////////////////////////
	// download control and data stream
	////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			addr           <= '0;
			wr_pend        <= 1'b0;
			ioctl_wr       <= 1'b0;
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
		end else begin
			// write strobe trails the data word by one cycle
			ioctl_wr <= wr_pend;
			wr_pend  <= 1'b0;

			if (data_strobe) begin
				case (cmd)
					CMD_FILE_INDEX: begin
						ioctl_index <= io_din[7:0];
					end

					CMD_FILE_TX: begin
						if (io_din[7:0] != 8'h00) begin
							// start of transfer
							addr           <= '0;
							ioctl_download <= 1'b1;
						end else begin
							// stop, leave the byte count on the address
							ioctl_addr     <= addr;
							ioctl_download <= 1'b0;
						end
					end

					CMD_FILE_TX_DAT: begin
						ioctl_addr <= addr;
						ioctl_dout <= io_din[7:0];
						wr_pend    <= 1'b1;
						addr       <= addr + 1'b1;
					end

					default: ;
				endcase
			end
		end
	end

endmodule

// ==== hdl/hps_io_top.sv ====
`timescale 1ns/1ps

module hps_io_top
	import hps_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       io_enable,
	input  logic       io_strobe,
	input  bus_word_t  io_din,
	output bus_word_t  io_dout,
	input  status_t    status_in,
	input  logic       status_set,
	output logic [1:0] buttons,
	output logic       forced_scandoubler,
	output status_t    status,
	output joy_t       joystick_0,
	output joy_t       joystick_1,
	output joy_t       joystick_2,
	output joy_t       joystick_3,
	output key_event_t ps2_key,
	output logic       ioctl_download,
	output logic [7:0] ioctl_index,
	output logic       ioctl_wr,
	output dl_addr_t   ioctl_addr,
	output logic [7:0] ioctl_dout
);

	logic      cmd_strobe;
	logic      data_strobe;
	logic      frame_end;
	cmd_t      cmd;
	word_idx_t word_idx;
	bus_word_t settings_rdata;

	////////////////////////////////////////
	// framing
	////////////////////////////////////////

	hps_cmd_frame u_frame (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.io_enable   (io_enable),
		.io_strobe   (io_strobe),
		.io_din      (io_din),
		.cmd_strobe  (cmd_strobe),
		.data_strobe (data_strobe),
		.cmd         (cmd),
		.word_idx    (word_idx),
		.frame_end   (frame_end)
	);

	////////////////////////////////////////
	// function blocks
	////////////////////////////////////////

	hps_settings_regs u_settings (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.cmd_strobe         (cmd_strobe),
		.data_strobe        (data_strobe),
		.frame_end          (frame_end),
		.cmd                (cmd),
		.word_idx           (word_idx),
		.io_din             (io_din),
		.status_in          (status_in),
		.status_set         (status_set),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.status             (status),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.joystick_2         (joystick_2),
		.joystick_3         (joystick_3),
		.rdata              (settings_rdata)
	);

	ps2_key_decoder u_kbd (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cmd_strobe  (cmd_strobe),
		.data_strobe (data_strobe),
		.frame_end   (frame_end),
		.cmd         (cmd),
		.io_din      (io_din),
		.ps2_key     (ps2_key)
	);

	file_download u_download (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.data_strobe    (data_strobe),
		.cmd            (cmd),
		.io_din         (io_din),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

	// only the settings block answers on the return bus, silent outside a frame
	assign io_dout = io_enable ? settings_rdata : '0;

endmodule

// ==== testbench/tb_hps_io.sv ====
`timescale 1ns/1ps

module tb_hps_io
	import hps_pkg::*;
();

	localparam int DL_LEN     = 16;
	localparam int WAIT_LIMIT = 50;

	logic       clk_sys = 1'b0;
	logic       reset;
	logic       io_enable;
	logic       io_strobe;
	bus_word_t  io_din;
	bus_word_t  io_dout;
	status_t    status_in;
	logic       status_set;
	logic [1:0] buttons;
	logic       forced_scandoubler;
	status_t    status;
	joy_t       joystick_0;
	joy_t       joystick_1;
	joy_t       joystick_2;
	joy_t       joystick_3;
	key_event_t ps2_key;
	logic       ioctl_download;
	logic [7:0] ioctl_index;
	logic       ioctl_wr;
	dl_addr_t   ioctl_addr;
	logic [7:0] ioctl_dout;

	int         seed = 32'h34c98d16;
	int         checks = 0;
	int         errors = 0;
	logic       timed_out = 1'b0;
	bus_word_t  tx_words [64];
	bus_word_t  rx_words [64];
	logic [7:0] dl_bytes [DL_LEN];
	int         dl_len = 0;
	int         wr_count = 0;
	joy_t       exp_joy [NUM_JOY];
	key_event_t exp_key = '0;
	cmd_t       joy_cmds [NUM_JOY] = '{CMD_JOY0, CMD_JOY1, CMD_JOY2, CMD_JOY3};

	hps_io_top uut (.*);

	always #4 clk_sys = ~clk_sys;

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	function automatic bus_word_t rand_word();
		logic [31:0] r;
		r = $random(seed);
		return r[15:0];
	endfunction

	// two payload words, low half first
	function automatic joy_t ref_two_word_reg(input bus_word_t w1, input bus_word_t w2);
		return {w2, w1};
	endfunction

	// {forced_scandoubler, buttons} from the config byte
	function automatic logic [2:0] ref_cfg_outputs(input logic [7:0] cfg);
		return {cfg[4], cfg[1:0]};
	endfunction

	function automatic bus_word_t ref_status_reply(input int idx, input logic [3:0] cnt,
		input status_t cap);
		if (idx == 0) return {8'h00, STATUS_REQ_TAG, cnt};
		if (idx == 1) return cap[15:0];
		return cap[31:16];
	endfunction

	// seq holds n scan bytes, the last one in bits 7..0
	function automatic key_event_t ref_key_event(input logic [63:0] seq, input int n,
		input logic prev_toggle);
		logic pressed;
		logic ext;
		logic [7:0] code;
		code    = seq[7:0];
		pressed = !(n >= 2 && seq[15:8] == 8'hF0);
		if (pressed) ext = (n >= 2 && seq[15:8] == 8'hE0);
		else ext = (n >= 3 && seq[23:16] == 8'hE0);
		// print screen and pause are multi-byte keys with fixed events
		if (n == 4 && seq[31:0] == 32'hE012_E07C) {pressed, ext, code} = {2'b11, 8'h7C};
		if (n == 6 && seq[47:0] == 48'hE0F0_7CE0_F012) {pressed, ext, code} = {2'b01, 8'h7C};
		if (n == 8 && seq[63:56] == 8'hE1) {pressed, ext, code} = {2'b11, 8'h77};
		return {~prev_toggle, pressed, ext, code};
	endfunction

	////////////////////////////////////////
	// bus tasks and checks
	////////////////////////////////////////

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	// called on a falling edge, returns one falling edge after the key update
	task automatic send_frame(input int len);
		int i;
		int n;
		io_enable = 1'b1;
		@(negedge clk_sys);
		for (i = 0; i < len; i++) begin
			io_din    = tx_words[i];
			io_strobe = 1'b1;
			@(negedge clk_sys);
			io_strobe = 1'b0;
			@(negedge clk_sys);
			rx_words[i] = io_dout;
		end
		io_enable = 1'b0;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
			// return bus is silent as soon as the frame is closed
			if (n == 1) begin
				check("io_dout", 64'(io_dout), 64'd0);
			end
		end while (!uut.frame_end && n < WAIT_LIMIT);
		if (!uut.frame_end) begin
			$display("Timeout: frame end never seen after enable dropped");
			timed_out = 1'b1;
		end
		@(negedge clk_sys);
	endtask

	task automatic write_two_words(input cmd_t cmd, input bus_word_t lo, input bus_word_t hi);
		tx_words[0] = cmd;
		tx_words[1] = lo;
		tx_words[2] = hi;
		send_frame(3);
	endtask

	task automatic key_case(input logic [63:0] seq, input int n);
		int i;
		exp_key     = ref_key_event(seq, n, exp_key[10]);
		tx_words[0] = CMD_KBD;
		for (i = 0; i < n; i++) begin
			tx_words[i + 1] = {8'h00, seq[8 * (n - 1 - i) +: 8]};
		end
		send_frame(n + 1);
		check("ps2_key", 64'(ps2_key), 64'(exp_key));
	endtask

	task automatic pulse_status_set(input status_t value);
		status_in  = value;
		status_set = 1'b1;
		@(negedge clk_sys);
		status_set = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic check_joysticks();
		check("joystick_0", 64'(joystick_0), 64'(exp_joy[0]));
		check("joystick_1", 64'(joystick_1), 64'(exp_joy[1]));
		check("joystick_2", 64'(joystick_2), 64'(exp_joy[2]));
		check("joystick_3", 64'(joystick_3), 64'(exp_joy[3]));
	endtask

	task automatic end_test(input string name, input int errs_at_start);
		if (errors == errs_at_start) $display("test %s: ok", name);
		else $display("test %s: failed with %0d errors", name, errors - errs_at_start);
	endtask

	// every write strobe must carry the next byte of the stream
	always @(negedge clk_sys) begin
		if (!reset && ioctl_wr) begin
			if (wr_count < dl_len) begin
				check("ioctl_addr", 64'(ioctl_addr), 64'(wr_count));
				check("ioctl_dout", 64'(ioctl_dout), 64'(dl_bytes[wr_count]));
				check("ioctl_download", 64'(ioctl_download), 64'd1);
			end else begin
				errors++;
				$display("Error at %0t ns: ioctl_wr pulsed with no byte left to write", $time);
			end
			wr_count++;
		end
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		int         t0;
		int         i;
		int         n;
		bus_word_t  lo;
		bus_word_t  hi;
		logic [2:0] exp_cfg;
		status_t    exp_status;
		status_t    cap;
		logic [7:0] idx;

		reset      = 1'b1;
		io_enable  = 1'b0;
		io_strobe  = 1'b0;
		io_din     = '0;
		status_in  = '0;
		status_set = 1'b0;
		repeat (3) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		t0 = errors;
		for (i = 0; i < NUM_JOY; i++) exp_joy[i] = '0;
		check("status", 64'(status), 64'd0);
		check_joysticks();
		check("buttons", 64'(buttons), 64'd0);
		check("ps2_key", 64'(ps2_key), 64'd0);
		check("ioctl_wr", 64'(ioctl_wr), 64'd0);
		check("ioctl_download", 64'(ioctl_download), 64'd0);
		end_test("reset values", t0);

		t0 = errors;
		lo          = rand_word();
		tx_words[0] = CMD_CFG;
		tx_words[1] = lo;
		send_frame(2);
		exp_cfg = ref_cfg_outputs(lo[7:0]);
		check("buttons", 64'(buttons), 64'(exp_cfg[1:0]));
		check("forced_scandoubler", 64'(forced_scandoubler), 64'(exp_cfg[2]));
		lo = rand_word();
		hi = rand_word();
		write_two_words(CMD_STATUS, lo, hi);
		exp_status = ref_two_word_reg(lo, hi);
		check("status", 64'(status), 64'(exp_status));
		for (i = 0; i < NUM_JOY; i++) begin
			lo = rand_word();
			hi = rand_word();
			write_two_words(joy_cmds[i], lo, hi);
			exp_joy[i] = ref_two_word_reg(lo, hi);
			check_joysticks();
		end
		end_test("settings registers", t0);

		t0 = errors;
		pulse_status_set({rand_word(), rand_word()});
		cap = {rand_word(), rand_word()};
		pulse_status_set(cap);
		write_two_words(CMD_STATUS_REQ, 16'h0000, 16'h0000);
		for (i = 0; i < 3; i++) begin
			check("io_dout", 64'(rx_words[i]), 64'(ref_status_reply(i, 4'd2, cap)));
		end
		check("io_dout", 64'(io_dout), 64'd0);
		end_test("status request", t0);

		t0 = errors;
		key_case(64'h1C, 1);
		key_case(64'hF01C, 2);
		key_case(64'hE075, 2);
		key_case(64'hE0F075, 3);
		key_case(64'hE012E07C, 4);
		key_case(64'hE0F07CE0F012, 6);
		key_case(64'hE11477E1F014F077, 8);
		// a skipped frame publishes nothing
		write_two_words(CMD_KBD, 16'hFF00, 16'h001C);
		check("ps2_key", 64'(ps2_key), 64'(exp_key));
		end_test("keyboard events", t0);

		t0 = errors;
		lo          = rand_word();
		idx         = lo[7:0];
		tx_words[0] = CMD_FILE_INDEX;
		tx_words[1] = {8'h00, idx};
		send_frame(2);
		check("ioctl_index", 64'(ioctl_index), 64'(idx));
		tx_words[0] = CMD_FILE_TX;
		tx_words[1] = 16'h0001;
		send_frame(2);
		check("ioctl_download", 64'(ioctl_download), 64'd1);
		tx_words[0] = CMD_FILE_TX_DAT;
		for (i = 0; i < DL_LEN; i++) begin
			tx_words[i + 1] = rand_word();
			dl_bytes[i]     = tx_words[i + 1][7:0];
		end
		wr_count = 0;
		dl_len   = DL_LEN;
		send_frame(DL_LEN + 1);
		n = 0;
		do begin
			@(posedge clk_sys);
			n++;
		end while (wr_count < dl_len && n < WAIT_LIMIT);
		if (wr_count < dl_len) begin
			$display("Timeout: only %0d of %0d download writes seen", wr_count, dl_len);
			timed_out = 1'b1;
		end
		@(negedge clk_sys);
		check("ioctl_wr count", 64'(wr_count), 64'(DL_LEN));
		tx_words[0] = CMD_FILE_TX;
		tx_words[1] = 16'h0000;
		send_frame(2);
		check("ioctl_download", 64'(ioctl_download), 64'd0);
		check("ioctl_addr", 64'(ioctl_addr), 64'(DL_LEN));
		end_test("file download", t0);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0 && !timed_out) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
hdl/hps_pkg.sv
hdl/hps_cmd_frame.sv
hdl/hps_settings_regs.sv
hdl/ps2_key_decoder.sv
hdl/file_download.sv
hdl/hps_io_top.sv
testbench/tb_hps_io.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --Mdir obj_dir --top-module tb_hps_io -o tb_hps_io -f vlog.f
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/tb_hps_io > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q ">>> FAIL" sim.log; then
	exit 1
fi
exit 0
